//--- hw/addr_pkg.sv
package addr_pkg;

    localparam int byte_w = 8;
    localparam int reg_w = 3;

    typedef logic [byte_w-1:0] byte_t;
    typedef logic [reg_w-1:0] reg_code_t;

    // 16-bit register numbers
    localparam reg_code_t reg_bx = 3'd3;
    localparam reg_code_t reg_bp = 3'd5;
    localparam reg_code_t reg_si = 3'd6;
    localparam reg_code_t reg_di = 3'd7;

    // modrm field values with special meaning
    localparam logic [1:0] mod_esc = 2'd3;
    localparam reg_code_t rm_sib = 3'd4;
    localparam reg_code_t rm_disp32 = 3'd5;
    localparam reg_code_t rm_disp16 = 3'd6;

    typedef struct packed {
        byte_t modrm;
        byte_t sib;
    } modrm_bytes_t;

    // modrm + sib + displacement
    typedef struct packed {
        logic [2:0] mem_len;
        logic [2:0] disp_len;
        reg_code_t base_reg;
        logic use_base;
        reg_code_t index_reg;
        logic use_index;
        logic [1:0] scale_shift;
        logic has_sib;
        logic [1:0] pad;
    } addr_fields_t;

endpackage

//--- hw/modrm_window_select.sv
module modrm_window_select #(
    parameter int max_prefixes = 3
) (
    input addr_pkg::byte_t [0:max_prefixes+2] window,
    input logic [$clog2(max_prefixes+1)-1:0] prefix_count,
    input logic two_byte_op,
    output addr_pkg::modrm_bytes_t bytes
);
    import addr_pkg::*;

    localparam int win_len = max_prefixes + 3;
    localparam int pos_w = $clog2(win_len);

    logic [pos_w-1:0] modrm_pos;
    logic [pos_w-1:0] sib_pos;

    // prefixes first, then the second opcode byte if there is one
    assign modrm_pos = pos_w'(prefix_count) + pos_w'(two_byte_op);
    assign sib_pos = modrm_pos + pos_w'(1);

    always_comb begin
        bytes = '0;
        for (int i = 0; i < win_len; i++) begin
            if (modrm_pos == pos_w'(i)) begin
                bytes.modrm = window[i];
            end
            if (sib_pos == pos_w'(i)) begin
                bytes.sib = window[i];
            end
        end
    end

endmodule

//--- hw/decode_16.sv
module decode_16 (
    input addr_pkg::modrm_bytes_t bytes,
    output addr_pkg::addr_fields_t fields
);
    import addr_pkg::*;

    logic [1:0] mod_bits;
    reg_code_t rm;

    assign mod_bits = bytes.modrm[7:6];
    assign rm = bytes.modrm[2:0];

    always_comb begin
        fields = '0;

        case (mod_bits)
            2'd1: fields.disp_len = 3'd1;
            2'd2: fields.disp_len = 3'd2;
            mod_esc: fields.disp_len = 3'd0;
            default: fields.disp_len = (rm == rm_disp16) ? 3'd2 : 3'd0;
        endcase
        fields.mem_len = 3'd1 + fields.disp_len;

        if (mod_bits == mod_esc) begin
            // register operand without memory access
            fields.base_reg = rm;
            fields.use_base = 1'b1;
        end else begin
            case (rm)
                3'd0, 3'd1, 3'd2, 3'd3: begin
                    fields.base_reg = rm[1] ? reg_bp : reg_bx;
                    fields.index_reg = rm[0] ? reg_di : reg_si;
                    fields.use_base = 1'b1;
                    fields.use_index = 1'b1;
                end
                3'd4: begin
                    fields.base_reg = reg_si;
                    fields.use_base = 1'b1;
                end
                3'd5: begin
                    fields.base_reg = reg_di;
                    fields.use_base = 1'b1;
                end
                3'd6: begin
                    // mod 0 here is a bare disp16
                    fields.base_reg = reg_bp;
                    fields.use_base = (mod_bits != 2'd0);
                end
                default: begin
                    fields.base_reg = reg_bx;
                    fields.use_base = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hw/decode_32.sv
module decode_32 (
    input addr_pkg::modrm_bytes_t bytes,
    output addr_pkg::addr_fields_t fields
);
    import addr_pkg::*;

    logic [1:0] mod_bits;
    reg_code_t rm;
    logic sib_present;
    logic [2:0] disp_len;

    assign mod_bits = bytes.modrm[7:6];
    assign rm = bytes.modrm[2:0];
    assign sib_present = (mod_bits != mod_esc) && (rm == rm_sib);

    always_comb begin
        case (mod_bits)
            2'd0: disp_len = (rm == rm_disp32) ? 3'd4 : 3'd0;
            2'd1: disp_len = 3'd1;
            2'd2: disp_len = 3'd4;
            default: disp_len = 3'd0;
        endcase
    end

    always_comb begin
        fields = '0;
        fields.disp_len = disp_len;
        fields.mem_len = 3'd1 + 3'(sib_present) + disp_len;
        fields.has_sib = sib_present;

        // mod 0 rm 5 is absolute disp32
        fields.use_base = !((mod_bits == 2'd0) && (rm == rm_disp32));

        if (sib_present) begin
            fields.base_reg = bytes.sib[2:0];
            fields.index_reg = bytes.sib[5:3];
            fields.scale_shift = bytes.sib[7:6];
            fields.use_index = 1'b1;
        end else begin
            fields.base_reg = rm;
        end
    end

endmodule

//--- hw/addr_mode_merge.sv
module addr_mode_merge (
    input logic clk,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input logic addr16,
    input logic has_modrm,
    input addr_pkg::addr_fields_t fields_16,
    input addr_pkg::addr_fields_t fields_32,
    output logic out_valid,
    input logic out_ready,
    output addr_pkg::addr_fields_t out_fields
);
    import addr_pkg::*;

    addr_fields_t selected;
    logic accept;

    // stage empties when the consumer takes the held result
    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;

    always_comb begin
        if (!has_modrm) begin
            selected = '0;
        end else if (addr16) begin
            selected = fields_16;
        end else begin
            selected = fields_32;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // result held until accepted downstream
    always_ff @(posedge clk) begin
        if (accept) begin
            out_fields <= selected;
        end
    end

endmodule

//--- hw/addressing_decode.sv
module addressing_decode #(
    parameter int max_prefixes = 3
) (
    input logic clk,
    input logic reset,

    input logic in_valid,
    output logic in_ready,
    input addr_pkg::byte_t [0:max_prefixes+2] window,
    input logic [$clog2(max_prefixes+1)-1:0] prefix_count,
    input logic two_byte_op,
    input logic has_modrm,
    input logic addr16,

    output logic out_valid,
    input logic out_ready,
    output addr_pkg::addr_fields_t out_fields
);
    import addr_pkg::*;

    modrm_bytes_t modrm_bytes;
    addr_fields_t fields_16;
    addr_fields_t fields_32;

    modrm_window_select #(
        .max_prefixes(max_prefixes)
    ) i_window_select (
        .window(window),
        .prefix_count(prefix_count),
        .two_byte_op(two_byte_op),
        .bytes(modrm_bytes)
    );

    // both widths decoded in parallel
    decode_16 i_decode_16 (
        .bytes(modrm_bytes),
        .fields(fields_16)
    );

    decode_32 i_decode_32 (
        .bytes(modrm_bytes),
        .fields(fields_32)
    );

    addr_mode_merge i_merge (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .addr16(addr16),
        .has_modrm(has_modrm),
        .fields_16(fields_16),
        .fields_32(fields_32),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_fields(out_fields)
    );

endmodule

//--- verif/addressing_decode_tb.sv
module addressing_decode_tb;
    import addr_pkg::*;

    localparam int max_prefixes = 3;
    localparam int win_len = max_prefixes + 3;
    localparam int pc_w = $clog2(max_prefixes + 1);
    localparam int num_vectors = 32;
    localparam int num_cols = 13;
    localparam int clk_period = 20;
    localparam int drive_delay = 2;
    localparam int reset_cycles = 5;
    localparam int timeout_cycles = num_vectors * 20 + reset_cycles;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    byte_t [0:win_len-1] window;
    logic [pc_w-1:0] prefix_count;
    logic two_byte_op;
    logic has_modrm;
    logic addr16;
    logic out_valid;
    logic out_ready;
    addr_fields_t out_fields;

    // 13 words per vector in data file column order
    logic [47:0] vec_mem [0:num_vectors*num_cols-1];
    logic [31:0] rng_state;
    int acc_count;
    int rcv_count;
    int pass_count;
    int fail_count;
    int extra_count;
    int hs_errors;
    logic test_ok;
    logic exp_valid;
    logic exp_ready;

    addressing_decode #(
        .max_prefixes(max_prefixes)
    ) i_addressing_decode (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .window(window),
        .prefix_count(prefix_count),
        .two_byte_op(two_byte_op),
        .has_modrm(has_modrm),
        .addr16(addr16),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_fields(out_fields)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_field(input string name, input int test, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t test %0d: %s is %0d, expected %0d",
                     $time, test, name, got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_response(input int v);
        int w;
        w = v * num_cols;
        test_ok = 1'b1;
        check_field("mem_len", v, 8'(out_fields.mem_len), vec_mem[w+5][7:0]);
        check_field("disp_len", v, 8'(out_fields.disp_len), vec_mem[w+6][7:0]);
        check_field("base_reg", v, 8'(out_fields.base_reg), vec_mem[w+7][7:0]);
        check_field("use_base", v, 8'(out_fields.use_base), vec_mem[w+8][7:0]);
        check_field("index_reg", v, 8'(out_fields.index_reg), vec_mem[w+9][7:0]);
        check_field("use_index", v, 8'(out_fields.use_index), vec_mem[w+10][7:0]);
        check_field("scale_shift", v, 8'(out_fields.scale_shift), vec_mem[w+11][7:0]);
        check_field("has_sib", v, 8'(out_fields.has_sib), vec_mem[w+12][7:0]);
        check_field("pad", v, 8'(out_fields.pad), 8'd0);
        if (test_ok) begin
            pass_count++;
            $display("test %0d: pass", v);
        end else begin
            fail_count++;
            $display("test %0d: failed", v);
        end
    endtask

    task automatic load_request(input int v);
        int w;
        w = v * num_cols;
        window = vec_mem[w];
        prefix_count = vec_mem[w+1][pc_w-1:0];
        two_byte_op = vec_mem[w+2][0];
        has_modrm = vec_mem[w+3][0];
        addr16 = vec_mem[w+4][0];
        in_valid = 1'b1;
    endtask

    // ready sampled mid-cycle for the transfer at the next rising edge
    task automatic wait_accept;
        logic took;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #drive_delay;
        end
    endtask

    initial begin : driver
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        window = '0;
        prefix_count = '0;
        two_byte_op = 1'b0;
        has_modrm = 1'b0;
        addr16 = 1'b0;
        acc_count = 0;
        rcv_count = 0;
        pass_count = 0;
        fail_count = 0;
        extra_count = 0;
        hs_errors = 0;
        $readmemh("verif/addressing_tests.txt", vec_mem);
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        if (out_valid !== 1'b0) begin
            $display("[FAIL] t=%0t reset: out_valid is %b, expected 0", $time, out_valid);
            fail_count++;
            $display("test reset: failed");
        end else begin
            pass_count++;
            $display("test reset: pass");
        end
        for (int v = 0; v < num_vectors; v++) begin
            load_request(v);
            wait_accept();
            acc_count++;
        end
        in_valid = 1'b0;
    end

    initial begin : receiver
        out_ready = 1'b0;
        rng_state = 32'd2;
        wait (reset === 1'b0);
        while (rcv_count < num_vectors) begin
            @(posedge clk);
            #drive_delay;
            rng_state = xorshift32(rng_state);
            out_ready = (rng_state[1:0] != 2'b00);
            @(negedge clk);
            // one item in flight at most, one cycle after its accept
            exp_valid = (acc_count != rcv_count);
            exp_ready = !exp_valid || out_ready;
            if (out_valid !== exp_valid || in_ready !== exp_ready) begin
                $display("[FAIL] t=%0t handshake: out_valid %b in_ready %b, expected %b %b",
                         $time, out_valid, in_ready, exp_valid, exp_ready);
                hs_errors++;
            end
            if (out_valid && out_ready) begin
                check_response(rcv_count);
                rcv_count++;
            end
        end
        @(posedge clk);
        #drive_delay;
        out_ready = 1'b1;
        // nothing may follow the last result
        repeat (3) begin
            @(negedge clk);
            if (out_valid) begin
                $display("unexpected extra response at t=%0t after the last test", $time);
                extra_count++;
            end
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d extra responses, %0d %s",
                 num_vectors + 1, pass_count, fail_count, extra_count, hs_errors,
                 "handshake errors");
        if (fail_count == 0 && extra_count == 0 && hs_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_cycles * clk_period);
        $display("run timed out with %0d of %0d responses missing",
                 num_vectors - rcv_count, num_vectors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verif/addressing_tests.txt
// window (byte 0 first) prefix_count two_byte_op has_modrm addr16, then expected:
// mem_len disp_len base_reg use_base index_reg use_index scale_shift has_sib
10c0c0c0c0c0 0 0 1 0 1 0 0 1 0 0 0 0
05c0c0c0c0c0 0 0 1 0 5 4 5 0 0 0 0 0
43c0c0c0c0c0 0 0 1 0 2 1 3 1 0 0 0 0
86c0c0c0c0c0 0 0 1 0 5 4 6 1 0 0 0 0
c4c0c0c0c0c0 0 0 1 0 1 0 4 1 0 0 0 0
45c0c0c0c0c0 0 0 1 0 2 1 5 1 0 0 0 0
0488c0c0c0c0 0 0 1 0 2 0 0 1 1 1 2 1
4cd3c0c0c0c0 0 0 1 0 3 1 3 1 2 1 3 1
8425c0c0c0c0 0 0 1 0 6 4 5 1 4 1 0 1
0465c0c0c0c0 0 0 1 0 2 0 5 1 4 1 1 1
00c0c0c0c0c0 0 0 1 1 1 0 3 1 6 1 0 0
01c0c0c0c0c0 0 0 1 1 1 0 3 1 7 1 0 0
02c0c0c0c0c0 0 0 1 1 1 0 5 1 6 1 0 0
03c0c0c0c0c0 0 0 1 1 1 0 5 1 7 1 0 0
04c0c0c0c0c0 0 0 1 1 1 0 6 1 0 0 0 0
05c0c0c0c0c0 0 0 1 1 1 0 7 1 0 0 0 0
06c0c0c0c0c0 0 0 1 1 3 2 5 0 0 0 0 0
07c0c0c0c0c0 0 0 1 1 1 0 3 1 0 0 0 0
46c0c0c0c0c0 0 0 1 1 2 1 5 1 0 0 0 0
49c0c0c0c0c0 0 0 1 1 2 1 3 1 7 1 0 0
9bc0c0c0c0c0 0 0 1 1 3 2 5 1 7 1 0 0
84c0c0c0c0c0 0 0 1 1 3 2 6 1 0 0 0 0
d2c0c0c0c0c0 0 0 1 1 1 0 2 1 0 0 0 0
66441ac0c0c0 1 0 1 0 3 1 2 1 3 1 0 1
66f38c2dc0c0 2 0 1 0 6 4 5 1 5 1 0 1
66f3af0c7fc0 2 1 1 0 2 0 7 1 7 1 1 1
66f32e85ffc0 3 0 1 0 5 4 5 1 0 0 0 0
66f32e3804b1 3 1 1 0 2 0 1 1 6 1 2 1
384ac0c0c0c0 0 1 1 1 2 1 5 1 6 1 0 0
673806c0c0c0 1 1 1 1 3 2 5 0 0 0 0 0
8425c0c0c0c0 0 0 0 0 0 0 0 0 0 0 0 0
46c0c0c0c0c0 0 0 0 1 0 0 0 0 0 0 0 0

//--- vlog.f
hw/addr_pkg.sv
hw/modrm_window_select.sv
hw/decode_16.sv
hw/decode_32.sv
hw/addr_mode_merge.sv
hw/addressing_decode.sv
verif/addressing_decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the addressing decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module addressing_decode_tb \
    -o addressing_decode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/addressing_decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
